// ==== src/rv32i_pkg.sv ====
//==============================
// Shared widths, opcodes, APB map and instruction views
// for the APB-loaded RV32I core
//==============================
package rv32i_pkg;

    localparam int xlen       = 32;
    localparam int imem_words = 256;
    localparam int imem_aw    = 8;    // Indexed by pc[9:2]
    localparam int dmem_words = 256;
    localparam int dmem_aw    = 8;

    //==============================
    // APB address map
    //==============================
    localparam int apb_aw = 12;
    localparam logic [apb_aw-1:0] apb_imem_base   = 12'h000;  // Program words
    localparam logic [apb_aw-1:0] apb_ctrl_addr   = 12'h400;  // Bit 0 run
    localparam logic [apb_aw-1:0] apb_status_addr = 12'h404;  // Bit 1 illegal, bit 0 halted
    localparam logic [apb_aw-1:0] apb_pc_addr     = 12'h408;
    localparam logic [apb_aw-1:0] apb_reg_base    = 12'h500;  // x0 to x31

    //==============================
    // Opcodes and function codes
    //==============================
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_fence  = 7'b0001111;
    localparam logic [6:0] op_system = 7'b1110011;

    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_word = 3'b010;  // LW and SW
    localparam logic [2:0] f3_sr   = 3'b101;  // SRL and SRA share it
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;  // SUB and SRA

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
    } alu_op_t;

    // Register-register view of an instruction word
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_view_t;

    // Immediate view, also used for the system encodings
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_view_t;

    typedef union packed {
        r_view_t r;
        i_view_t i;
    } rv32i_instr_t;

endpackage

// ==== src/rv32i_imem.sv ====
//==============================
// Program memory between the APB loader and the core
// Synchronous write, combinational fetch read
//==============================
`timescale 1ns/1ps

module rv32i_imem (
    input  logic                             clk,
    input  logic                             we,
    input  logic [rv32i_pkg::imem_aw-1:0]    waddr,
    input  logic [rv32i_pkg::xlen-1:0]       wdata,
    input  logic [rv32i_pkg::imem_aw-1:0]    raddr,
    output logic [rv32i_pkg::xlen-1:0]       rdata
);

    logic [rv32i_pkg::xlen-1:0] mem [rv32i_pkg::imem_words];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;  // Loader writes land at the end of the access phase
        end
    end

    // Fetch sees the word in the same cycle
    assign rdata = mem[raddr];

endmodule

// ==== src/rv32i_apb_loader.sv ====
//==============================
// APB slave that loads the program, holds the run bit and
// reads back status, pc and the integer registers
//==============================
`timescale 1ns/1ps

module rv32i_apb_loader (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             psel,
    input  logic                             penable,
    input  logic                             pwrite,
    input  logic [rv32i_pkg::apb_aw-1:0]     paddr,
    input  logic [rv32i_pkg::xlen-1:0]       pwdata,
    output logic [rv32i_pkg::xlen-1:0]       prdata,
    output logic                             pready,
    output logic                             pslverr,
    output logic                             imem_we,
    output logic [rv32i_pkg::imem_aw-1:0]    imem_waddr,
    output logic [rv32i_pkg::xlen-1:0]       imem_wdata,
    output logic                             run,
    input  logic                             halted,
    input  logic                             illegal,
    input  logic [rv32i_pkg::xlen-1:0]       pc,
    output logic [4:0]                       dbg_reg_idx,
    input  logic [rv32i_pkg::xlen-1:0]       dbg_reg_data
);

    logic setup, access;
    logic hit_imem, hit_ctrl, hit_status, hit_pc, hit_reg;
    logic wr_err;
    logic [rv32i_pkg::xlen-1:0] rd_word;

    assign setup  = psel & ~penable;
    assign access = psel & penable;

    //==============================
    // Address decode
    //==============================
    assign hit_imem   = paddr[rv32i_pkg::apb_aw-1:rv32i_pkg::imem_aw+2] ==
                        rv32i_pkg::apb_imem_base[rv32i_pkg::apb_aw-1:rv32i_pkg::imem_aw+2];
    assign hit_ctrl   = paddr == rv32i_pkg::apb_ctrl_addr;
    assign hit_status = paddr == rv32i_pkg::apb_status_addr;
    assign hit_pc     = paddr == rv32i_pkg::apb_pc_addr;
    assign hit_reg    = paddr[rv32i_pkg::apb_aw-1:7] == rv32i_pkg::apb_reg_base[rv32i_pkg::apb_aw-1:7];

    // Program is locked while running, readback words are read-only
    assign wr_err  = pwrite & ((hit_imem & run) | hit_status | hit_pc | hit_reg);
    assign pslverr = access & (wr_err | ~(hit_imem | hit_ctrl | hit_status | hit_pc | hit_reg));
    assign pready  = 1'b1;  // No wait states

    assign imem_we     = access & pwrite & hit_imem & ~run;
    assign imem_waddr  = paddr[rv32i_pkg::imem_aw+1:2];
    assign imem_wdata  = pwdata;
    assign dbg_reg_idx = paddr[6:2];

    assign rd_word = hit_ctrl   ? {{(rv32i_pkg::xlen-1){1'b0}}, run} :
                     hit_status ? {{(rv32i_pkg::xlen-2){1'b0}}, illegal, halted} :
                     hit_pc     ? pc :
                     hit_reg    ? dbg_reg_data : '0;  // imem is write-only

    always_ff @(posedge clk) begin
        if (rst) begin
            run    <= 1'b0;
            prdata <= '0;
        end else begin
            if (setup && !pwrite) begin
                prdata <= rd_word;  // Valid during the access phase
            end
            if (access && pwrite && hit_ctrl) begin
                run <= pwdata[0];
            end
        end
    end

endmodule

// ==== src/rv32i_alu.sv ====
//==============================
// Integer ALU for OP, OP-IMM, address and LUI results
//==============================
`timescale 1ns/1ps

module rv32i_alu (
    input  rv32i_pkg::alu_op_t              op,
    input  logic [rv32i_pkg::xlen-1:0]      a,
    input  logic [rv32i_pkg::xlen-1:0]      b,
    output logic [rv32i_pkg::xlen-1:0]      y
);

    logic [4:0] shamt;

    assign shamt = b[4:0];  // Shift amount for register and immediate shifts

    always_comb begin
        case (op)
            rv32i_pkg::alu_add:    y = a + b;
            rv32i_pkg::alu_sub:    y = a - b;
            rv32i_pkg::alu_sll:    y = a << shamt;
            rv32i_pkg::alu_slt: begin
                // Signed compare for SLT and SLTI
                y = {{(rv32i_pkg::xlen-1){1'b0}}, $signed(a) < $signed(b)};
            end
            rv32i_pkg::alu_sltu:   y = {{(rv32i_pkg::xlen-1){1'b0}}, a < b};
            rv32i_pkg::alu_xor:    y = a ^ b;
            rv32i_pkg::alu_srl:    y = a >> shamt;
            rv32i_pkg::alu_sra:    y = $signed(a) >>> shamt;
            rv32i_pkg::alu_or:     y = a | b;
            rv32i_pkg::alu_and:    y = a & b;
            rv32i_pkg::alu_pass_b: y = b;  // LUI
            default:               y = '0;
        endcase
    end

endmodule

// ==== src/rv32i_regfile.sv ====
//==============================
// 32 integer registers, two read ports, one write port
// and a debug port for APB readback
//==============================
`timescale 1ns/1ps

module rv32i_regfile (
    input  logic                             clk,
    input  logic                             we,
    input  logic [4:0]                       waddr,
    input  logic [rv32i_pkg::xlen-1:0]       wdata,
    input  logic [4:0]                       raddr1,
    input  logic [4:0]                       raddr2,
    input  logic [4:0]                       dbg_idx,
    output logic [rv32i_pkg::xlen-1:0]       rdata1,
    output logic [rv32i_pkg::xlen-1:0]       rdata2,
    output logic [rv32i_pkg::xlen-1:0]       dbg_data
);

    logic [rv32i_pkg::xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 reads as zero on every port
    assign rdata1   = (raddr1 == 5'd0)  ? '0 : regs[raddr1];
    assign rdata2   = (raddr2 == 5'd0)  ? '0 : regs[raddr2];
    assign dbg_data = (dbg_idx == 5'd0) ? '0 : regs[dbg_idx];

endmodule

// ==== src/rv32i_core.sv ====
//==============================
// Single-cycle RV32I execution core
// Retires one instruction per clock while run is set
//==============================
`timescale 1ns/1ps

module rv32i_core (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             run,
    output logic [rv32i_pkg::imem_aw-1:0]    fetch_addr,
    input  rv32i_pkg::rv32i_instr_t          fetch_instr,
    output logic                             halted,
    output logic                             illegal,
    output logic [rv32i_pkg::xlen-1:0]       pc,
    input  logic [4:0]                       dbg_reg_idx,
    output logic [rv32i_pkg::xlen-1:0]       dbg_reg_data
);

    logic [6:0] opcode, funct7;
    logic [2:0] funct3;
    logic [4:0] rd, rs1, rs2;
    logic [11:0] imm12;
    logic [rv32i_pkg::xlen-1:0] imm_u, imm_i, imm_s, imm_b, imm_j;
    logic [rv32i_pkg::xlen-1:0] rs1_data, rs2_data, alu_a, alu_b, alu_y;
    logic [rv32i_pkg::xlen-1:0] rd_data, ld_data, pc_plus4, next_pc;
    rv32i_pkg::alu_op_t alu_op, f3_op;
    logic rf_we, dmem_we, taken, stop, bad, step;
    logic [rv32i_pkg::xlen-1:0] dmem [rv32i_pkg::dmem_words];

    //==============================
    // Fields and immediates
    //==============================
    assign opcode = fetch_instr.r.opcode;
    assign funct3 = fetch_instr.r.funct3;
    assign funct7 = fetch_instr.r.funct7;
    assign rd     = fetch_instr.r.rd;
    assign rs1    = fetch_instr.r.rs1;
    assign rs2    = fetch_instr.r.rs2;
    assign imm12  = fetch_instr.i.imm12;

    assign imm_i = {{20{imm12[11]}}, imm12};
    assign imm_u = {funct7, rs2, rs1, funct3, 12'b0};
    assign imm_s = {{20{funct7[6]}}, funct7, rd};
    assign imm_b = {{20{funct7[6]}}, rd[0], funct7[5:0], rd[4:1], 1'b0};
    assign imm_j = {{12{funct7[6]}}, rs1, funct3, rs2[0], funct7[5:0], rs2[4:1], 1'b0};

    assign fetch_addr = pc[rv32i_pkg::imem_aw+1:2];
    assign pc_plus4   = pc + 32'd4;
    assign step       = run & ~halted;
    assign ld_data    = dmem[alu_y[rv32i_pkg::dmem_aw+1:2]];

    always_comb begin  // Base ALU op per funct3, shared by OP and OP-IMM
        case (funct3)
            3'b000:  f3_op = rv32i_pkg::alu_add;
            3'b001:  f3_op = rv32i_pkg::alu_sll;
            3'b010:  f3_op = rv32i_pkg::alu_slt;
            3'b011:  f3_op = rv32i_pkg::alu_sltu;
            3'b100:  f3_op = rv32i_pkg::alu_xor;
            3'b101:  f3_op = rv32i_pkg::alu_srl;
            3'b110:  f3_op = rv32i_pkg::alu_or;
            default: f3_op = rv32i_pkg::alu_and;
        endcase
    end

    //==============================
    // Decode and next pc
    //==============================
    always_comb begin
        alu_op  = rv32i_pkg::alu_add;
        alu_a   = rs1_data;
        alu_b   = rs2_data;
        rd_data = alu_y;
        next_pc = pc_plus4;
        rf_we   = 1'b0;
        dmem_we = 1'b0;
        taken   = 1'b0;
        stop    = 1'b0;
        bad     = 1'b0;
        case (opcode)
            rv32i_pkg::op_lui: begin
                alu_op = rv32i_pkg::alu_pass_b;
                alu_b  = imm_u;
                rf_we  = 1'b1;
            end
            rv32i_pkg::op_auipc: begin
                alu_a = pc;
                alu_b = imm_u;
                rf_we = 1'b1;
            end
            rv32i_pkg::op_jal: begin
                rd_data = pc_plus4;  // Link
                rf_we   = 1'b1;
                next_pc = pc + imm_j;
            end
            rv32i_pkg::op_jalr: begin
                alu_b   = imm_i;
                rd_data = pc_plus4;
                rf_we   = 1'b1;
                next_pc = {alu_y[rv32i_pkg::xlen-1:1], 1'b0};
                bad     = funct3 != 3'b000;
            end
            rv32i_pkg::op_branch: begin
                case (funct3)
                    3'b000:  taken = rs1_data == rs2_data;
                    3'b001:  taken = rs1_data != rs2_data;
                    3'b100:  taken = $signed(rs1_data) < $signed(rs2_data);
                    3'b101:  taken = $signed(rs1_data) >= $signed(rs2_data);
                    3'b110:  taken = rs1_data < rs2_data;
                    3'b111:  taken = rs1_data >= rs2_data;
                    default: bad = 1'b1;
                endcase
                if (taken) begin
                    next_pc = pc + imm_b;
                end
            end
            rv32i_pkg::op_load: begin
                alu_b   = imm_i;
                rd_data = ld_data;
                rf_we   = 1'b1;
                bad     = funct3 != rv32i_pkg::f3_word;  // LW only
            end
            rv32i_pkg::op_store: begin
                alu_b   = imm_s;
                dmem_we = 1'b1;
                bad     = funct3 != rv32i_pkg::f3_word;
            end
            rv32i_pkg::op_imm: begin
                alu_op = f3_op;
                alu_b  = imm_i;
                rf_we  = 1'b1;
                if (funct3 == rv32i_pkg::f3_sr && funct7 == rv32i_pkg::f7_alt) begin
                    alu_op = rv32i_pkg::alu_sra;
                end else if ((funct3 == rv32i_pkg::f3_sll || funct3 == rv32i_pkg::f3_sr) &&
                             funct7 != rv32i_pkg::f7_base) begin
                    bad = 1'b1;  // Bad shift encoding
                end
            end
            rv32i_pkg::op_reg: begin
                alu_op = f3_op;
                rf_we  = 1'b1;
                if (funct7 == rv32i_pkg::f7_alt && funct3 == rv32i_pkg::f3_add) begin
                    alu_op = rv32i_pkg::alu_sub;
                end else if (funct7 == rv32i_pkg::f7_alt && funct3 == rv32i_pkg::f3_sr) begin
                    alu_op = rv32i_pkg::alu_sra;
                end else if (funct7 != rv32i_pkg::f7_base) begin
                    bad = 1'b1;
                end
            end
            rv32i_pkg::op_fence: begin
                // Nothing to order in a single-cycle core
            end
            rv32i_pkg::op_system: begin
                // ECALL has imm12 of 0 and EBREAK of 1
                stop = imm12[11:1] == '0 && rs1 == '0 && funct3 == '0 && rd == '0;
                bad  = ~stop;
            end
            default: bad = 1'b1;
        endcase
        if (bad) begin
            rf_we   = 1'b0;
            dmem_we = 1'b0;
        end
    end

    //==============================
    // State
    //==============================
    always_ff @(posedge clk) begin
        if (rst || !run) begin
            pc      <= '0;
            halted  <= 1'b0;
            illegal <= 1'b0;
        end else if (!halted) begin
            if (stop || bad) begin
                halted  <= 1'b1;  // pc stays on the halting instruction
                illegal <= bad;
            end else begin
                pc <= next_pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (step && dmem_we) begin
            dmem[alu_y[rv32i_pkg::dmem_aw+1:2]] <= rs2_data;
        end
    end

    rv32i_alu u_alu (
        .op (alu_op),
        .a  (alu_a),
        .b  (alu_b),
        .y  (alu_y)
    );

    rv32i_regfile u_regfile (
        .clk      (clk),
        .we       (step & rf_we),
        .waddr    (rd),
        .wdata    (rd_data),
        .raddr1   (rs1),
        .raddr2   (rs2),
        .dbg_idx  (dbg_reg_idx),
        .rdata1   (rs1_data),
        .rdata2   (rs2_data),
        .dbg_data (dbg_reg_data)
    );

endmodule

// ==== src/rv32i_top.sv ====
//==============================
// Top level of the APB-programmed RV32I core
//==============================
`timescale 1ns/1ps

module rv32i_top (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             psel,
    input  logic                             penable,
    input  logic                             pwrite,
    input  logic [rv32i_pkg::apb_aw-1:0]     paddr,
    input  logic [rv32i_pkg::xlen-1:0]       pwdata,
    output logic [rv32i_pkg::xlen-1:0]       prdata,
    output logic                             pready,
    output logic                             pslverr
);

    logic                           imem_we;
    logic [rv32i_pkg::imem_aw-1:0]  imem_waddr, fetch_addr;
    logic [rv32i_pkg::xlen-1:0]     imem_wdata, fetch_instr;
    logic                           run, halted, illegal;
    logic [rv32i_pkg::xlen-1:0]     pc, dbg_reg_data;
    logic [4:0]                     dbg_reg_idx;

    // Program producer
    rv32i_apb_loader u_loader (
        .clk          (clk),
        .rst          (rst),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .imem_we      (imem_we),
        .imem_waddr   (imem_waddr),
        .imem_wdata   (imem_wdata),
        .run          (run),
        .halted       (halted),
        .illegal      (illegal),
        .pc           (pc),
        .dbg_reg_idx  (dbg_reg_idx),
        .dbg_reg_data (dbg_reg_data)
    );

    rv32i_imem u_imem (
        .clk   (clk),
        .we    (imem_we),
        .waddr (imem_waddr),
        .wdata (imem_wdata),
        .raddr (fetch_addr),
        .rdata (fetch_instr)
    );

    rv32i_core u_core (
        .clk          (clk),
        .rst          (rst),
        .run          (run),
        .fetch_addr   (fetch_addr),
        .fetch_instr  (fetch_instr),
        .halted       (halted),
        .illegal      (illegal),
        .pc           (pc),
        .dbg_reg_idx  (dbg_reg_idx),
        .dbg_reg_data (dbg_reg_data)
    );

endmodule

// ==== verif/rv32i_sva.sv ====
//==============================
// APB and run-control assertions, bound into the loader
//==============================
`timescale 1ns/1ps

module rv32i_sva (
    input logic clk,
    input logic rst,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic pslverr,
    input logic imem_we,
    input logic run
);

    int unsigned fail_count = 0;  // Read by the testbench at the end of the run

    // No wait states in the access phase
    a_pready_high: assert property (@(posedge clk) disable iff (rst)
        psel && penable |-> pready)
        else begin
            $error("pready low during an APB access phase");
            fail_count++;
        end

    a_enable_after_select: assert property (@(posedge clk) disable iff (rst)
        $rose(penable) |-> $past(psel))
        else begin
            $error("penable rose without a setup phase");
            fail_count++;
        end

    a_slverr_in_access: assert property (@(posedge clk) disable iff (rst)
        !(psel && penable) |-> !pslverr)
        else begin
            $error("pslverr high outside an access phase");
            fail_count++;
        end

    // Program is locked while the core runs
    a_imem_locked: assert property (@(posedge clk) disable iff (rst)
        !(imem_we && run))
        else begin
            $error("imem written while run is set");
            fail_count++;
        end

endmodule

bind rv32i_apb_loader rv32i_sva u_sva (.*);

// ==== verif/rv32i_tb.sv ====
//==============================
// Testbench for the APB-loaded RV32I core
// Loads program tables, runs to halt, checks registers
//==============================
`timescale 1ns/1ps

module rv32i_tb;

    logic        clk = 1'b0;
    logic        rst, psel, penable, pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata, prdata;
    logic        pready, pslverr;

    logic [31:0] prog_main[$];
    logic [31:0] prog_illegal[$];
    int          exp_idx[$];
    logic [31:0] exp_val[$];
    int          seed;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    always #4 clk = ~clk;  // 8 ns period

    rv32i_top u_dut (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    //==============================
    // Instruction encoders
    //==============================
    function automatic logic [31:0] enc_i(logic [6:0] opc, logic [2:0] f3, logic [4:0] rd,
                                          logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_imm(logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1,
                                            logic [11:0] imm);
        return enc_i(rv32i_pkg::op_imm, f3, rd, rs1, imm);
    endfunction

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                          logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, rv32i_pkg::op_reg};
    endfunction

    function automatic logic [31:0] enc_b(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                          logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv32i_pkg::op_branch};
    endfunction

    function automatic logic [31:0] enc_u(logic [6:0] opc, logic [4:0] rd, logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_j(logic [4:0] rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, rv32i_pkg::op_jal};
    endfunction

    // SW with rs2 as data and rs1 as base
    function automatic logic [31:0] enc_sw(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv32i_pkg::op_store};
    endfunction

    task automatic add_exp(input int idx, input logic [31:0] val);
        exp_idx.push_back(idx);
        exp_val.push_back(val);
    endtask

    task automatic build_tables;
        logic [31:0] rnd, val_a, val_b;
        seed  = 22;
        rnd   = $random(seed);
        val_a = {{20{rnd[11]}}, rnd[11:0]};
        rnd   = $random(seed);
        val_b = {{20{rnd[11]}}, rnd[11:0]};
        prog_main = '{
            enc_imm(3'b000, 1, 0, val_a[11:0]),            // 0x00 addi x1, random
            enc_imm(3'b000, 2, 0, val_b[11:0]),            // 0x04 addi x2, random
            enc_r(7'h00, 3'b000, 3, 1, 2),                 // add
            enc_r(7'h20, 3'b000, 4, 1, 2),                 // sub
            enc_imm(3'b000, 5, 0, 12'hff0),                // x5 = -16
            enc_imm(3'b101, 6, 5, 12'h402),                // srai by 2
            enc_imm(3'b101, 7, 5, 12'd28),                 // srli by 28
            enc_r(7'h00, 3'b010, 8, 5, 7),                 // slt
            enc_r(7'h00, 3'b011, 9, 5, 7),                 // sltu
            enc_imm(3'b010, 10, 5, 12'hfff),               // slti -1
            enc_imm(3'b100, 11, 7, 12'h05a),
            enc_imm(3'b110, 12, 7, 12'h100),
            enc_imm(3'b111, 13, 5, 12'h07f),
            enc_imm(3'b001, 14, 7, 12'd8),                 // slli
            enc_u(rv32i_pkg::op_lui, 15, 20'h12345),
            enc_u(rv32i_pkg::op_auipc, 16, 20'h00001),     // 0x3c
            enc_imm(3'b000, 0, 0, 12'd5),                  // write to x0
            enc_r(7'h00, 3'b100, 17, 5, 7),
            enc_r(7'h00, 3'b001, 18, 7, 7),                // sll by 15
            enc_imm(3'b000, 19, 0, 12'd7),
            enc_imm(3'b000, 20, 0, 12'd7),
            enc_b(3'b000, 7, 7, 13'd8),                    // 0x54 beq taken
            enc_imm(3'b000, 19, 0, 12'd99),                // Skipped
            enc_b(3'b001, 7, 7, 13'd8),                    // bne not taken
            enc_imm(3'b000, 21, 0, 12'd33),
            enc_j(22, 21'd8),                              // 0x64 jal
            enc_imm(3'b000, 20, 0, 12'd99),                // Skipped
            enc_imm(3'b000, 23, 0, 12'd124),
            enc_i(rv32i_pkg::op_jalr, 3'b000, 24, 23, 12'd0),  // 0x70 jalr to 0x7c
            enc_imm(3'b000, 19, 0, 12'd55),                // Skipped
            enc_imm(3'b000, 20, 0, 12'd55),                // Skipped
            enc_sw(15, 0, 12'h040),
            enc_i(rv32i_pkg::op_load, 3'b010, 25, 0, 12'h040),
            32'h0ff0000f,                                  // fence
            32'h00000073                                   // 0x88 ecall
        };
        add_exp(0, 32'h0);
        add_exp(1, val_a);
        add_exp(2, val_b);
        add_exp(3, val_a + val_b);
        add_exp(4, val_a - val_b);
        add_exp(5, 32'hffff_fff0);
        add_exp(6, 32'hffff_fffc);
        add_exp(7, 32'h0000_000f);
        add_exp(8, 32'h1);     // -16 < 15 signed
        add_exp(9, 32'h0);
        add_exp(10, 32'h1);
        add_exp(11, 32'h55);
        add_exp(12, 32'h10f);
        add_exp(13, 32'h70);
        add_exp(14, 32'hf00);
        add_exp(15, 32'h1234_5000);
        add_exp(16, 32'h0000_103c);
        add_exp(17, 32'hffff_ffff);
        add_exp(18, 32'h0007_8000);
        add_exp(19, 32'd7);
        add_exp(20, 32'd7);
        add_exp(21, 32'd33);
        add_exp(22, 32'h68);   // jal link
        add_exp(23, 32'h7c);
        add_exp(24, 32'h74);   // jalr link
        add_exp(25, 32'h1234_5000);
        // Halts on the all-zero word at 0x08
        prog_illegal = '{enc_imm(3'b000, 5, 0, 12'h123), enc_imm(3'b000, 6, 5, 12'h001), 32'h0};
    endtask

    //==============================
    // Checks and APB tasks
    //==============================
    task stop_run;
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task check_value(input string name, input logic [31:0] actual, input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            stop_run();
        end
    endtask

    // Entered 1 ns after a rising edge, setup then access
    task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        psel    = 1'b1;  // Setup phase
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        rdata = prdata;  // Mid access phase
        err   = pslverr;
        check_value("pready", {31'b0, pready}, 32'h1);
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_expect(input logic [11:0] addr, input logic [31:0] data,
                                input logic exp_err);
        logic [31:0] unused;
        logic        err;
        apb_xfer(1'b1, addr, data, unused, err);
        check_value("pslverr", {31'b0, err}, {31'b0, exp_err});
    endtask

    task automatic read_expect(input string name, input logic [11:0] addr,
                               input logic [31:0] expected);
        logic [31:0] data;
        logic        err;
        apb_xfer(1'b0, addr, 32'h0, data, err);
        check_value("pslverr", {31'b0, err}, 32'h0);
        check_value(name, data, expected);
    endtask

    task automatic load_program(input logic [31:0] words[$]);
        for (int i = 0; i < words.size(); i++) begin
            write_expect(12'(i * 4), words[i], 1'b0);
        end
    endtask

    // Poll status until the halted bit is set
    task automatic wait_halt(input int max_polls);
        logic [31:0] status;
        logic        err;
        int          polls;
        polls = 0;
        apb_xfer(1'b0, rv32i_pkg::apb_status_addr, 32'h0, status, err);
        while (!status[0] && polls < max_polls) begin
            apb_xfer(1'b0, rv32i_pkg::apb_status_addr, 32'h0, status, err);
            polls++;
        end
        if (!status[0]) begin
            $display("ERROR: core never halted after %0d status polls", polls);
            stop_run();
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("ERROR: timeout, run still going after %0d cycles", cycle_count);
            stop_run();
        end
    end

    //==============================
    // Test sequence
    //==============================
    initial begin
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        build_tables();
        cycle_limit = 4 * (prog_main.size() + prog_illegal.size() + exp_idx.size() * 2 + 50);
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        read_expect("status", rv32i_pkg::apb_status_addr, 32'h0);
        read_expect("pc", rv32i_pkg::apb_pc_addr, 32'h0);
        write_expect(12'h7f0, 32'h1, 1'b1);  // Unmapped

        load_program(prog_main);
        write_expect(rv32i_pkg::apb_ctrl_addr, 32'h1, 1'b0);
        wait_halt(prog_main.size() + 10);
        read_expect("status", rv32i_pkg::apb_status_addr, 32'h1);
        read_expect("pc", rv32i_pkg::apb_pc_addr, 32'((prog_main.size() - 1) * 4));
        for (int i = 0; i < exp_idx.size(); i++) begin
            read_expect($sformatf("x%0d", exp_idx[i]),
                        rv32i_pkg::apb_reg_base + 12'(exp_idx[i] * 4), exp_val[i]);
        end
        write_expect(12'h000, 32'hdead_beef, 1'b1);  // Still running

        // Second program ends on an illegal word
        write_expect(rv32i_pkg::apb_ctrl_addr, 32'h0, 1'b0);
        load_program(prog_illegal);
        write_expect(rv32i_pkg::apb_ctrl_addr, 32'h1, 1'b0);
        wait_halt(prog_illegal.size() + 10);
        read_expect("status", rv32i_pkg::apb_status_addr, 32'h3);
        read_expect("pc", rv32i_pkg::apb_pc_addr, 32'((prog_illegal.size() - 1) * 4));
        read_expect("x6", rv32i_pkg::apb_reg_base + 12'h018, 32'h124);

        if (u_dut.u_loader.u_sva.fail_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display("ERROR: %0d APB assertion failures", u_dut.u_loader.u_sva.fail_count);
            stop_run();
        end
    end

endmodule

// ==== sim.f ====
src/rv32i_pkg.sv
src/rv32i_imem.sv
src/rv32i_apb_loader.sv
src/rv32i_alu.sv
src/rv32i_regfile.sv
src/rv32i_core.sv
src/rv32i_top.sv
verif/rv32i_sva.sv
verif/rv32i_tb.sv
